// File: Bender.yml
package:
  name: apb_periph

sources:
  - files:
      - verilog/apb_periph_pkg.sv
      - verilog/apb_slv.sv
      - verilog/apb_decoder.sv
      - verilog/gpio_regs.sv
      - verilog/timer_regs.sv
      - verilog/apb_periph.sv
  - target: test
    files:
      - tests/apb_periph_asserts.sv
      - tests/tb_apb_periph.sv

// File: apb_periph.f
verilog/apb_periph_pkg.sv
verilog/apb_slv.sv
verilog/apb_decoder.sv
verilog/gpio_regs.sv
verilog/timer_regs.sv
verilog/apb_periph.sv
tests/apb_periph_asserts.sv
tests/tb_apb_periph.sv

// File: tests/apb_periph_asserts.sv
// Bound checks on APB transfer timing and the shape of the internal strobes
`timescale 1ns/100ps

module apb_periph_asserts (
    input logic                     i_clk,
    input logic                     i_nrst,
    input apb_periph_pkg::apb_in_t  i_apbi,
    input apb_periph_pkg::apb_out_t i_apbo,
    input logic                     i_req_valid,    // Front end request strobe
    input logic                     i_resp_valid    // Merged response strobe
);

    int fail_count = 0;     // Number of failed assertions

    // Setup phase edge to pready is three cycles
    a_ready_latency: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_apbi.psel) |-> !i_apbi.penable ##0 !i_apbo.pready [*3] ##1 i_apbo.pready)
        else begin
            $error("pready did not rise 3 cycles after the setup phase");
            fail_count++;
        end

    a_req_after_setup: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_apbi.psel) |=> i_req_valid)
        else begin
            $error("No request strobe after the setup phase");
            fail_count++;
        end

    a_req_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |=> !i_req_valid)
        else begin
            $error("Request strobe longer than one cycle");
            fail_count++;
        end

    a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |=> !i_resp_valid)
        else begin
            $error("Response strobe longer than one cycle");
            fail_count++;
        end

    // Bus stays quiet outside a transfer
    a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_apbi.psel |-> !i_apbo.pready && !i_apbo.pslverr)
        else begin
            $error("pready or pslverr high while psel is low");
            fail_count++;
        end

endmodule

bind apb_periph apb_periph_asserts u_asserts (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_apbi       (i_apbi),
    .i_apbo       (o_apbo),
    .i_req_valid  (slv_req.valid),
    .i_resp_valid (slv_resp.valid)
);

// File: tests/tb_apb_periph.sv
// Testbench for the APB peripheral, runs APB transfers against GPIO, timer and descriptor
`timescale 1ns/100ps

module tb_apb_periph;

    localparam int          MAX_CYCLES  = 2000;   // About 60 transfers plus idle gaps and waits
    localparam int          READY_LIMIT = 16;
    localparam logic [31:0] GPIO_OUT_A  = 32'h4000_0000;
    localparam logic [31:0] GPIO_DIR_A  = 32'h4000_0004;
    localparam logic [31:0] GPIO_IN_A   = 32'h4000_0008;
    localparam logic [31:0] GPIO_RSV_A  = 32'h4000_000c;  // Unmapped GPIO offset
    localparam logic [31:0] TMR_CTRL_A  = 32'h4000_0100;
    localparam logic [31:0] TMR_COUNT_A = 32'h4000_0104;
    localparam logic [31:0] TMR_CMP_A   = 32'h4000_0108;
    localparam logic [31:0] TMR_STAT_A  = 32'h4000_010c;

    logic                       clk;
    logic                       nrst;
    apb_periph_pkg::map_info_t  mapinfo;
    apb_periph_pkg::apb_in_t    apbi;
    apb_periph_pkg::apb_out_t   o_apbo;
    apb_periph_pkg::dev_cfg_t   o_cfg;
    logic [15:0]                gpio_in;
    logic [15:0]                o_gpio_out;
    logic [15:0]                o_gpio_dir;
    logic                       o_timer_irq;

    logic [15:0] out_model;
    logic [15:0] dir_model;
    logic [31:0] rng;
    logic [31:0] rd;
    logic [31:0] c1;
    logic [31:0] c2;
    logic        err;
    int          check_errors = 0;
    int          hs_errors = 0;
    int          cycles = 0;

    apb_periph u_apb_periph (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_mapinfo   (mapinfo),
        .i_apbi      (apbi),
        .o_apbo      (o_apbo),
        .o_cfg       (o_cfg),
        .i_gpio_in   (gpio_in),
        .o_gpio_out  (o_gpio_out),
        .o_gpio_dir  (o_gpio_dir),
        .o_timer_irq (o_timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_word(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            check_errors++;
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            check_errors++;
        end
    endtask

    // Setup phase, access phase, then wait for pready
    task automatic transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int waited;
        waited = 0;
        rdata  = '0;
        slverr = 1'b0;
        @(negedge clk);
        apbi.psel    = 1'b1;
        apbi.penable = 1'b0;
        apbi.pwrite  = wr;
        apbi.paddr   = addr;
        apbi.pwdata  = wdata;
        @(negedge clk);
        apbi.penable = 1'b1;
        while (!o_apbo.pready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (o_apbo.pready) begin
            rdata  = o_apbo.prdata;
            slverr = o_apbo.pslverr;
        end else begin
            $display("Transfer to 0x%08h got no pready within %0d cycles", addr, READY_LIMIT);
            hs_errors++;
        end
        @(negedge clk);             // Edge between holds the access phase with pready
        apbi.psel    = 1'b0;
        apbi.penable = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata,
                             output logic slverr);
        logic [31:0] unused;
        transfer(1'b1, addr, wdata, unused, slverr);
        if (addr[apb_periph_pkg::UNIT_SEL_MSB:apb_periph_pkg::UNIT_SEL_LSB]
                == apb_periph_pkg::UNIT_GPIO) begin
            if (addr[3:2] == apb_periph_pkg::GPIO_OUT) out_model = wdata[15:0];
            if (addr[3:2] == apb_periph_pkg::GPIO_DIR) dir_model = wdata[15:0];
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        transfer(1'b0, addr, 32'd0, rdata, slverr);
    endtask

    initial begin
        nrst               = 1'b0;
        apbi               = '0;
        mapinfo.addr_start = 32'h4000_0000;
        mapinfo.addr_end   = 32'h4000_0fff;
        gpio_in            = '0;
        out_model          = '0;
        dir_model          = '0;
        rng                = 32'hd921_b8b9;
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        require_true(o_gpio_out == 0 && o_gpio_dir == 0 && !o_timer_irq, "Outputs after reset");

        // Descriptor, combinational from the map info
        compare_word(o_cfg.vid, apb_periph_pkg::VENDOR_ID, "Vendor ID");
        compare_word(o_cfg.did, apb_periph_pkg::DEVICE_ID, "Device ID");
        compare_word(o_cfg.descr_type, apb_periph_pkg::DESCR_TYPE_SLAVE, "Descriptor type");
        compare_word(o_cfg.addr_start, 32'h4000_0000, "Window start");
        @(negedge clk);
        mapinfo.addr_start = 32'h8000_2000;
        mapinfo.addr_end   = 32'h8000_2fff;
        #1;
        compare_word(o_cfg.addr_start, 32'h8000_2000, "Window start after change");
        compare_word(o_cfg.addr_end, 32'h8000_2fff, "Window end after change");

        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            write_reg(GPIO_OUT_A, rng, err);
            compare_word(o_gpio_out, out_model, "o_gpio_out");
            rng = xorshift32(rng);
            write_reg(GPIO_DIR_A, rng, err);
            compare_word(o_gpio_dir, dir_model, "o_gpio_dir");
            read_reg(GPIO_OUT_A, rd, err);
            compare_word(rd, {16'h0, out_model}, "GPIO_OUT read");
            read_reg(GPIO_DIR_A, rd, err);
            compare_word(rd, {16'h0, dir_model}, "GPIO_DIR read");
            require_true(!err, "pslverr on GPIO_DIR read");
            rng = xorshift32(rng);
            @(negedge clk);
            gpio_in = rng[15:0];
            repeat (3) @(negedge clk);
            read_reg(GPIO_IN_A, rd, err);
            compare_word(rd, {16'h0, gpio_in}, "GPIO_IN read");
        end

        // Error responses leave the GPIO registers alone
        write_reg(GPIO_IN_A, xorshift32(rng), err);
        require_true(err, "No pslverr on write to GPIO_IN");
        read_reg(GPIO_RSV_A, rd, err);
        require_true(err, "No pslverr on read of GPIO offset 3");
        write_reg(GPIO_RSV_A, 32'hffff_ffff, err);
        require_true(err, "No pslverr on write to GPIO offset 3");
        read_reg(32'h4000_0200, rd, err);
        require_true(err, "No pslverr on read of unit 2");
        compare_word(rd, 32'd0, "Unmapped unit read data");
        write_reg(32'h4000_0f00, 32'h1234_5678, err);
        require_true(err, "No pslverr on write to unit 15");
        compare_word(o_gpio_out, out_model, "o_gpio_out after error accesses");
        compare_word(o_gpio_dir, dir_model, "o_gpio_dir after error accesses");

        // Timer counting
        write_reg(TMR_COUNT_A, 32'd0, err);
        write_reg(TMR_CTRL_A, 32'd1, err);
        read_reg(TMR_COUNT_A, c1, err);
        repeat (8) @(negedge clk);
        read_reg(TMR_COUNT_A, c2, err);
        require_true(c2 > c1 && !err, "Counter did not increase while enabled");
        write_reg(TMR_CTRL_A, 32'd0, err);
        read_reg(TMR_COUNT_A, c1, err);
        repeat (8) @(negedge clk);
        read_reg(TMR_COUNT_A, c2, err);
        compare_word(c2, c1, "Counter while disabled");

        // Compare match and sticky flag
        write_reg(TMR_CMP_A, 32'd8, err);
        write_reg(TMR_COUNT_A, 32'd0, err);
        require_true(!o_timer_irq, "o_timer_irq before enable");
        write_reg(TMR_CTRL_A, 32'd1, err);
        repeat (12) @(negedge clk);
        require_true(o_timer_irq, "o_timer_irq not set after compare match");
        read_reg(TMR_STAT_A, rd, err);
        compare_word(rd, 32'd1, "TMR_STATUS read");
        write_reg(TMR_STAT_A, 32'd1, err);
        require_true(!o_timer_irq, "o_timer_irq not cleared by STATUS write");
        write_reg(TMR_CTRL_A, 32'd0, err);

        repeat (2) @(negedge clk);
        $display("Done: %0d check errors, %0d handshake errors, %0d assertion errors",
                 check_errors, hs_errors, u_apb_periph.u_asserts.fail_count);
        if (check_errors + hs_errors + u_apb_periph.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog/apb_decoder.sv
// Address decoder, steers requests to a unit and merges the unit responses
`timescale 1ns/100ps

module apb_decoder (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  apb_periph_pkg::bus_req_t  i_req,
    output apb_periph_pkg::bus_req_t  o_gpio_req,
    output apb_periph_pkg::bus_req_t  o_timer_req,
    input  apb_periph_pkg::bus_resp_t i_gpio_resp,
    input  apb_periph_pkg::bus_resp_t i_timer_resp,
    output apb_periph_pkg::bus_resp_t o_resp
);

    localparam int SEL_W = apb_periph_pkg::UNIT_SEL_MSB - apb_periph_pkg::UNIT_SEL_LSB + 1;

    logic [SEL_W-1:0] unit_sel;
    logic             sel_gpio;
    logic             sel_timer;
    logic             err_valid;       // Own response for unmapped units

    assign unit_sel  = i_req.addr[apb_periph_pkg::UNIT_SEL_MSB:apb_periph_pkg::UNIT_SEL_LSB];
    assign sel_gpio  = (unit_sel == apb_periph_pkg::UNIT_GPIO);
    assign sel_timer = (unit_sel == apb_periph_pkg::UNIT_TIMER);

    always_comb begin
        o_gpio_req        = i_req;
        o_gpio_req.valid  = i_req.valid & sel_gpio;
        o_timer_req       = i_req;
        o_timer_req.valid = i_req.valid & sel_timer;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            err_valid <= 1'b0;
        end else begin
            err_valid <= i_req.valid & ~sel_gpio & ~sel_timer;
        end
    end

    // Sources are one-hot, so a plain OR picks the active one
    always_comb begin
        o_resp.valid = i_gpio_resp.valid | i_timer_resp.valid | err_valid;
        o_resp.rdata = ({32{i_gpio_resp.valid}} & i_gpio_resp.rdata)
                     | ({32{i_timer_resp.valid}} & i_timer_resp.rdata);
        o_resp.err   = (i_gpio_resp.valid & i_gpio_resp.err)
                     | (i_timer_resp.valid & i_timer_resp.err)
                     | err_valid;
    end

endmodule

// File: verilog/apb_periph.sv
// APB peripheral top, front end and decoder in front of the GPIO and timer units
`timescale 1ns/100ps

module apb_periph (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    input  apb_periph_pkg::map_info_t             i_mapinfo,
    input  apb_periph_pkg::apb_in_t               i_apbi,
    output apb_periph_pkg::apb_out_t              o_apbo,
    output apb_periph_pkg::dev_cfg_t              o_cfg,
    input  logic [apb_periph_pkg::GPIO_WIDTH-1:0] i_gpio_in,
    output logic [apb_periph_pkg::GPIO_WIDTH-1:0] o_gpio_out,
    output logic [apb_periph_pkg::GPIO_WIDTH-1:0] o_gpio_dir,
    output logic                                  o_timer_irq
);

    apb_periph_pkg::bus_req_t  slv_req;
    apb_periph_pkg::bus_resp_t slv_resp;     // Merged response
    apb_periph_pkg::bus_req_t  gpio_req;
    apb_periph_pkg::bus_resp_t gpio_resp;
    apb_periph_pkg::bus_req_t  timer_req;
    apb_periph_pkg::bus_resp_t timer_resp;

    apb_slv u_apb_slv (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_mapinfo (i_mapinfo),
        .o_cfg     (o_cfg),
        .i_apbi    (i_apbi),
        .o_apbo    (o_apbo),
        .o_req     (slv_req),
        .i_resp    (slv_resp)
    );

    apb_decoder u_apb_decoder (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req        (slv_req),
        .o_gpio_req   (gpio_req),
        .o_timer_req  (timer_req),
        .i_gpio_resp  (gpio_resp),
        .i_timer_resp (timer_resp),
        .o_resp       (slv_resp)
    );

    gpio_regs u_gpio_regs (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req      (gpio_req),
        .o_resp     (gpio_resp),
        .i_gpio_in  (i_gpio_in),
        .o_gpio_out (o_gpio_out),
        .o_gpio_dir (o_gpio_dir)
    );

    timer_regs u_timer_regs (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (timer_req),
        .o_resp      (timer_resp),
        .o_timer_irq (o_timer_irq)
    );

endmodule

// File: verilog/apb_periph_pkg.sv
// APB peripheral package with bus structs, state and register enums, address map and IDs
package apb_periph_pkg;

    localparam logic [1:0]  DESCR_TYPE_SLAVE = 2'h2;     // Descriptor type of a slave device
    localparam logic [15:0] VENDOR_ID        = 16'h00f1;
    localparam logic [15:0] DEVICE_ID        = 16'h0a81;
    localparam int          GPIO_WIDTH       = 16;       // Number of GPIO pins

    // Unit select field of the request address
    localparam int         UNIT_SEL_LSB = 8;
    localparam int         UNIT_SEL_MSB = 11;
    localparam logic [3:0] UNIT_GPIO    = 4'd0;
    localparam logic [3:0] UNIT_TIMER   = 4'd1;

    // Register select field within a unit
    localparam int REG_SEL_LSB = 2;
    localparam int REG_SEL_MSB = 3;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_in_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_out_t;

    typedef struct packed {
        logic [31:0] addr_start;
        logic [31:0] addr_end;
    } map_info_t;

    typedef struct packed {
        logic [1:0]  descr_type;
        logic [15:0] vid;
        logic [15:0] did;
        logic [31:0] addr_start;
        logic [31:0] addr_end;
    } dev_cfg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        err;
    } bus_resp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT_RESP,
        ST_RESP
    } slv_state_e;

    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_DIR = 2'd1,
        GPIO_IN  = 2'd2     // Read only
    } gpio_reg_e;

    typedef enum logic [1:0] {
        TMR_CTRL    = 2'd0, // Bit 0 enables counting
        TMR_COUNT   = 2'd1,
        TMR_COMPARE = 2'd2,
        TMR_STATUS  = 2'd3  // Write 1 to bit 0 clears the flag
    } timer_reg_e;

endpackage

// File: verilog/apb_slv.sv
// APB slave front end, turns APB transfers into request and response strobes
`timescale 1ns/100ps

module apb_slv (
    input  logic                      i_clk,
    input  logic                      i_nrst,      // Active low
    input  apb_periph_pkg::map_info_t i_mapinfo,   // Window assigned by the interconnect
    output apb_periph_pkg::dev_cfg_t  o_cfg,       // Plug-and-play descriptor
    input  apb_periph_pkg::apb_in_t   i_apbi,
    output apb_periph_pkg::apb_out_t  o_apbo,
    output apb_periph_pkg::bus_req_t  o_req,
    input  apb_periph_pkg::bus_resp_t i_resp
);

    apb_periph_pkg::slv_state_e state;
    apb_periph_pkg::slv_state_e state_nxt;

    logic        req_valid;
    logic        req_valid_nxt;
    logic [31:0] req_addr;
    logic        req_write;
    logic [31:0] req_wdata;
    logic        resp_valid;
    logic        resp_valid_nxt;
    logic        resp_err;
    logic        resp_err_nxt;
    logic [31:0] resp_rdata;
    logic        capture_req;
    logic        capture_resp;

    always_comb begin
        state_nxt      = state;
        req_valid_nxt  = 1'b0;         // Request is a single pulse
        resp_valid_nxt = resp_valid;
        resp_err_nxt   = resp_err;
        capture_req    = 1'b0;
        capture_resp   = 1'b0;

        case (state)
            apb_periph_pkg::ST_IDLE: begin
                resp_valid_nxt = 1'b0;
                resp_err_nxt   = 1'b0;
                if (i_apbi.psel) begin
                    state_nxt     = apb_periph_pkg::ST_REQUEST;
                    req_valid_nxt = 1'b1;
                    capture_req   = 1'b1;
                end
            end
            apb_periph_pkg::ST_REQUEST: begin
                state_nxt = apb_periph_pkg::ST_WAIT_RESP;  // One wait state
            end
            apb_periph_pkg::ST_WAIT_RESP: begin
                if (i_resp.valid) begin
                    state_nxt      = apb_periph_pkg::ST_RESP;
                    resp_valid_nxt = 1'b1;
                    resp_err_nxt   = i_resp.err;
                    capture_resp   = 1'b1;
                end
            end
            apb_periph_pkg::ST_RESP: begin
                // Hold pready until the master is in its access phase
                if (i_apbi.penable) begin
                    state_nxt      = apb_periph_pkg::ST_IDLE;
                    resp_valid_nxt = 1'b0;
                    resp_err_nxt   = 1'b0;
                end
            end
            default: state_nxt = apb_periph_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state      <= apb_periph_pkg::ST_IDLE;
            req_valid  <= 1'b0;
            resp_valid <= 1'b0;
            resp_err   <= 1'b0;
        end else begin
            state      <= state_nxt;
            req_valid  <= req_valid_nxt;
            resp_valid <= resp_valid_nxt;
            resp_err   <= resp_err_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture_req) begin
            req_addr  <= i_apbi.paddr;
            req_write <= i_apbi.pwrite;
            req_wdata <= i_apbi.pwdata;
        end
        if (capture_resp) begin
            resp_rdata <= i_resp.rdata;
        end
    end

    always_comb begin
        o_req.valid    = req_valid;
        o_req.addr     = req_addr;
        o_req.write    = req_write;
        o_req.wdata    = req_wdata;
        o_apbo.pready  = resp_valid;
        o_apbo.prdata  = resp_rdata;
        o_apbo.pslverr = resp_err;
    end

    // Descriptor follows the map info directly
    always_comb begin
        o_cfg.descr_type = apb_periph_pkg::DESCR_TYPE_SLAVE;
        o_cfg.vid        = apb_periph_pkg::VENDOR_ID;
        o_cfg.did        = apb_periph_pkg::DEVICE_ID;
        o_cfg.addr_start = i_mapinfo.addr_start;
        o_cfg.addr_end   = i_mapinfo.addr_end;
    end

endmodule

// File: verilog/gpio_regs.sv
// GPIO register unit with output, direction and synchronized input registers
`timescale 1ns/100ps

module gpio_regs (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    input  apb_periph_pkg::bus_req_t              i_req,
    output apb_periph_pkg::bus_resp_t             o_resp,
    input  logic [apb_periph_pkg::GPIO_WIDTH-1:0] i_gpio_in,   // Asynchronous pins
    output logic [apb_periph_pkg::GPIO_WIDTH-1:0] o_gpio_out,
    output logic [apb_periph_pkg::GPIO_WIDTH-1:0] o_gpio_dir   // 1 drives the pin
);

    localparam int W   = apb_periph_pkg::GPIO_WIDTH;
    localparam int PAD = 32 - W;

    logic [W-1:0] gpio_out;
    logic [W-1:0] gpio_dir;
    logic [W-1:0] sync_q1;
    logic [W-1:0] sync_q2;
    logic [1:0]   reg_sel;
    logic         bad_access;
    logic [31:0]  rdata_nxt;
    logic         wr_en;
    logic         resp_valid;
    logic         resp_err;
    logic [31:0]  resp_rdata;

    assign reg_sel = i_req.addr[apb_periph_pkg::REG_SEL_MSB:apb_periph_pkg::REG_SEL_LSB];

    always_comb begin
        bad_access = 1'b0;
        rdata_nxt  = '0;
        case (reg_sel)
            apb_periph_pkg::GPIO_OUT: rdata_nxt = {{PAD{1'b0}}, gpio_out};
            apb_periph_pkg::GPIO_DIR: rdata_nxt = {{PAD{1'b0}}, gpio_dir};
            apb_periph_pkg::GPIO_IN: begin
                rdata_nxt  = {{PAD{1'b0}}, sync_q2};
                bad_access = i_req.write;          // Input port is read only
            end
            default: bad_access = 1'b1;            // Offset 3 is unmapped
        endcase
    end

    assign wr_en = i_req.valid & i_req.write & ~bad_access;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            gpio_out   <= '0;
            gpio_dir   <= '0;
            resp_valid <= 1'b0;
            resp_err   <= 1'b0;
        end else begin
            resp_valid <= i_req.valid;
            if (i_req.valid) resp_err <= bad_access;
            if (wr_en && reg_sel == apb_periph_pkg::GPIO_OUT) gpio_out <= i_req.wdata[W-1:0];
            if (wr_en && reg_sel == apb_periph_pkg::GPIO_DIR) gpio_dir <= i_req.wdata[W-1:0];
        end
    end

    // Two-flop synchronizer and read data
    always_ff @(posedge i_clk) begin
        sync_q1 <= i_gpio_in;
        sync_q2 <= sync_q1;
        if (i_req.valid) resp_rdata <= rdata_nxt;
    end

    assign o_resp.valid = resp_valid;
    assign o_resp.rdata = resp_rdata;
    assign o_resp.err   = resp_err;
    assign o_gpio_out   = gpio_out;
    assign o_gpio_dir   = gpio_dir;

endmodule

// File: verilog/timer_regs.sv
// Timer register unit with free-running counter, compare and sticky interrupt flag
`timescale 1ns/100ps

module timer_regs (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  apb_periph_pkg::bus_req_t  i_req,
    output apb_periph_pkg::bus_resp_t o_resp,
    output logic                      o_timer_irq
);

    logic [1:0]  reg_sel;
    logic        enable;
    logic [31:0] count;
    logic [31:0] compare;
    logic        irq_flag;
    logic        wr_en;
    logic        match;
    logic [31:0] rdata_nxt;
    logic        resp_valid;
    logic [31:0] resp_rdata;

    assign reg_sel = i_req.addr[apb_periph_pkg::REG_SEL_MSB:apb_periph_pkg::REG_SEL_LSB];
    assign wr_en   = i_req.valid & i_req.write;
    assign match   = (count == compare);

    always_comb begin
        case (reg_sel)
            apb_periph_pkg::TMR_CTRL:    rdata_nxt = {31'd0, enable};
            apb_periph_pkg::TMR_COUNT:   rdata_nxt = count;
            apb_periph_pkg::TMR_COMPARE: rdata_nxt = compare;
            default:                     rdata_nxt = {31'd0, irq_flag};   // Status
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            enable     <= 1'b0;
            count      <= '0;
            compare    <= '1;          // Stays clear of the reset count
            irq_flag   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= i_req.valid;

            if (wr_en && reg_sel == apb_periph_pkg::TMR_CTRL) enable <= i_req.wdata[0];

            // Bus write wins over counting
            if (wr_en && reg_sel == apb_periph_pkg::TMR_COUNT) begin
                count <= i_req.wdata;
            end else if (enable) begin
                count <= count + 32'd1;
            end

            if (wr_en && reg_sel == apb_periph_pkg::TMR_COMPARE) compare <= i_req.wdata;

            // A match in the same cycle as a clear keeps the flag set
            if (match) begin
                irq_flag <= 1'b1;
            end else if (wr_en && reg_sel == apb_periph_pkg::TMR_STATUS && i_req.wdata[0]) begin
                irq_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.valid) resp_rdata <= rdata_nxt;
    end

    assign o_resp.valid = resp_valid;
    assign o_resp.rdata = resp_rdata;
    assign o_resp.err   = 1'b0;         // Every offset is mapped
    assign o_timer_irq  = irq_flag;

endmodule
